// ==== rtl/aznable_pkg.sv ====
package aznable_pkg;

	// Memory map
	localparam logic [15:0] MAP_IN0 = 16'h8000;
	localparam logic [15:0] MAP_TIMESTAMP_START = 16'h8002;
	localparam logic [15:0] MAP_TIMER_START = 16'h802A;
	localparam logic [15:0] MAP_JOYSTICK_START = 16'h803A;
	// Analog, spinner and mouse starts only close the windows before them
	localparam logic [15:0] MAP_ANALOG_L_START = 16'h80FA;
	localparam logic [15:0] MAP_PADDLE_START = 16'h81BA;
	localparam logic [15:0] MAP_SPINNER_START = 16'h81EA;
	localparam logic [15:0] MAP_PS2_KEY_START = 16'h824A;
	localparam logic [15:0] MAP_PS2_MOUSE_START = 16'h8256;
	localparam logic [15:0] MAP_SYSTEMPAUSE = 16'h82B6;
	localparam logic [15:0] MAP_SYSTEMMENU = 16'h82B7;
	localparam logic [15:0] MAP_WKRAM_START = 16'hC000;

	// Raster timing in pixel clocks and lines
	localparam logic [8:0] H_VISIBLE = 9'd320;
	localparam logic [8:0] H_TOTAL = 9'd384;
	localparam logic [8:0] HS_START = 9'd336;
	localparam logic [8:0] HS_END = 9'd352;
	localparam logic [8:0] V_VISIBLE = 9'd240;
	localparam logic [8:0] V_TOTAL = 9'd262;
	localparam logic [8:0] VS_START = 9'd244;
	localparam logic [8:0] VS_END = 9'd247;

	typedef struct packed {
		// Seconds in 31..0 and a toggle in bit 32
		logic [32:0] timestamp;
		// Six pads of 32 buttons
		logic [191:0] joystick;
		logic [47:0] paddle;
		logic [10:0] ps2_key;
	} host_inputs_t;

	typedef struct packed {
		logic hs;
		logic vs;
		logic hb;
		logic vb;
	} video_sync_t;

	typedef struct packed {
		logic in0;
		logic timestamp;
		logic timer;
		logic joystick;
		logic paddle;
		logic ps2_key;
		logic pause;
		logic menu;
		logic wkram;
	} bus_sel_t;

endpackage

// ==== rtl/raster_timer.sv ====
module raster_timer
	import aznable_pkg::*;
(
	input logic clk_24,
	input logic reset,
	input logic ce_6,
	output video_sync_t sync
);

	logic [8:0] hcnt;
	logic [8:0] vcnt;
	logic [8:0] hcnt_next;
	logic [8:0] vcnt_next;

	// Counters step once per pixel enable
	always_comb
	begin
		hcnt_next = hcnt;
		vcnt_next = vcnt;
		if (ce_6)
		begin
			if (hcnt == H_TOTAL - 9'd1)
			begin
				hcnt_next = 9'd0;
				if (vcnt == V_TOTAL - 9'd1)
					vcnt_next = 9'd0;
				else
					vcnt_next = vcnt + 9'd1;
			end
			else
			begin
				hcnt_next = hcnt + 9'd1;
			end
		end
	end

	// Sync and blanking follow the new count on the same edge
	always_ff @(posedge clk_24)
	begin
		if (reset)
		begin
			hcnt <= 9'd0;
			vcnt <= 9'd0;
			sync <= '0;
		end
		else
		begin
			hcnt <= hcnt_next;
			vcnt <= vcnt_next;
			sync.hb <= hcnt_next >= H_VISIBLE;
			sync.vb <= vcnt_next >= V_VISIBLE;
			sync.hs <= (hcnt_next >= HS_START) && (hcnt_next < HS_END);
			sync.vs <= (vcnt_next >= VS_START) && (vcnt_next < VS_END);
		end
	end

endmodule

// ==== rtl/ms_timer.sv ====
module ms_timer #(
	parameter int CYCLES_PER_MS = 24000
) (
	input logic clk_24,
	input logic reset,
	input logic timer_clear,
	output logic [15:0] count
);

	localparam int PRE_W = (CYCLES_PER_MS > 1) ? $clog2(CYCLES_PER_MS) : 1;
	localparam logic [PRE_W-1:0] PRE_LAST = PRE_W'(CYCLES_PER_MS - 1);

	logic [PRE_W-1:0] prescale;

	// A CPU write restarts both the prescaler and the count
	always_ff @(posedge clk_24)
	begin
		if (reset || timer_clear)
		begin
			prescale <= '0;
			count <= 16'd0;
		end
		else if (prescale == PRE_LAST)
		begin
			prescale <= '0;
			count <= count + 16'd1;
		end
		else
		begin
			prescale <= prescale + 1'b1;
		end
	end

endmodule

// ==== rtl/bus_decode.sv ====
module bus_decode
	import aznable_pkg::*;
(
	input logic [15:0] cpu_addr,
	input logic cpu_wr_n,
	output bus_sel_t sel,
	output logic timer_clear,
	output logic pause_set,
	output logic menu_clear
);

	// At most one region select is high
	always_comb
	begin
		sel = '0;
		sel.in0 = cpu_addr == MAP_IN0;
		sel.timestamp = (cpu_addr >= MAP_TIMESTAMP_START) &&
			(cpu_addr < MAP_TIMER_START);
		sel.timer = (cpu_addr >= MAP_TIMER_START) &&
			(cpu_addr < MAP_JOYSTICK_START);
		sel.joystick = (cpu_addr >= MAP_JOYSTICK_START) &&
			(cpu_addr < MAP_ANALOG_L_START);
		sel.paddle = (cpu_addr >= MAP_PADDLE_START) &&
			(cpu_addr < MAP_SPINNER_START);
		sel.ps2_key = (cpu_addr >= MAP_PS2_KEY_START) &&
			(cpu_addr < MAP_PS2_MOUSE_START);
		sel.pause = cpu_addr == MAP_SYSTEMPAUSE;
		sel.menu = cpu_addr == MAP_SYSTEMMENU;
		sel.wkram = cpu_addr >= MAP_WKRAM_START;
	end

	// Write strobes for the registers that react to a CPU write
	assign timer_clear = sel.timer && !cpu_wr_n;
	assign pause_set = sel.pause && !cpu_wr_n;
	assign menu_clear = sel.menu && !cpu_wr_n;

endmodule

// ==== rtl/system_regs.sv ====
module system_regs (
	input logic clk_24,
	input logic reset,
	input logic pause,
	input logic menu,
	input logic pause_set,
	input logic menu_clear,
	output logic pause_system,
	output logic menu_trigger
);

	logic pause_trigger;

	// Host pause releases a pause the CPU requested
	always_ff @(posedge clk_24)
	begin
		if (reset)
			pause_trigger <= 1'b0;
		else if (pause)
			pause_trigger <= 1'b0;
		else if (pause_set)
			pause_trigger <= 1'b1;
	end

	// Menu request is held until the CPU acknowledges it
	always_ff @(posedge clk_24)
	begin
		if (reset)
			menu_trigger <= 1'b0;
		else if (menu)
			menu_trigger <= 1'b1;
		else if (menu_clear)
			menu_trigger <= 1'b0;
	end

	assign pause_system = pause || pause_trigger;

endmodule

// ==== rtl/work_ram.sv ====
module work_ram
	import aznable_pkg::*;
#(
	parameter int RAM_ADDR_WIDTH = 14
) (
	input logic clk_24,
	input bus_sel_t sel,
	input logic [15:0] cpu_addr,
	input logic cpu_wr_n,
	input logic [7:0] cpu_dout,
	output logic [7:0] q
);

	logic [7:0] mem [2**RAM_ADDR_WIDTH];
	logic [RAM_ADDR_WIDTH-1:0] addr;
	logic wr_en;

	assign addr = cpu_addr[RAM_ADDR_WIDTH-1:0];
	assign wr_en = sel.wkram && !cpu_wr_n;

	// A write shows its own data on q
	always_ff @(posedge clk_24)
	begin
		if (wr_en)
		begin
			mem[addr] <= cpu_dout;
			q <= cpu_dout;
		end
		else
		begin
			q <= mem[addr];
		end
	end

endmodule

// ==== rtl/cpu_read_mux.sv ====
module cpu_read_mux
	import aznable_pkg::*;
(
	input logic clk_24,
	input logic reset,
	input logic [15:0] cpu_addr,
	input bus_sel_t sel,
	input host_inputs_t inputs,
	input video_sync_t sync,
	input logic menu,
	input logic [15:0] timer,
	input logic [7:0] ram_q,
	output logic [7:0] cpu_din
);

	logic [15:0] ts_off;
	logic [15:0] tm_off;
	logic [15:0] joy_off;
	logic [15:0] pad_off;
	logic [15:0] key_off;
	logic [7:0] status;
	logic [7:0] byte_next;
	logic [7:0] din_r;
	logic wkram_r;

	// Byte n of data, or 00 past the last valid byte of the window
	function automatic logic [7:0] byte_at(
		input logic [255:0] data,
		input logic [15:0] offset,
		input int unsigned nbytes
	);
		logic [7:0] b;
		b = 8'h00;
		if (offset < nbytes)
			b = data[{offset[4:0], 3'b000} +: 8];
		return b;
	endfunction

	assign ts_off = cpu_addr - MAP_TIMESTAMP_START;
	assign tm_off = cpu_addr - MAP_TIMER_START;
	assign joy_off = cpu_addr - MAP_JOYSTICK_START;
	assign pad_off = cpu_addr - MAP_PADDLE_START;
	assign key_off = cpu_addr - MAP_PS2_KEY_START;

	assign status = {sync.hs, sync.vs, sync.hb, sync.vb, 2'b10, menu, 1'b0};

	always_comb
	begin
		byte_next = 8'h00;
		if (sel.in0)
			byte_next = status;
		else if (sel.timestamp)
			byte_next = byte_at(256'(inputs.timestamp), ts_off, 5);
		else if (sel.timer)
			byte_next = byte_at(256'(timer), tm_off, 2);
		else if (sel.joystick)
			byte_next = byte_at(256'(inputs.joystick), joy_off, 24);
		else if (sel.paddle)
			byte_next = byte_at(256'(inputs.paddle), pad_off, 6);
		else if (sel.ps2_key)
			byte_next = byte_at(256'(inputs.ps2_key), key_off, 2);
		else if (sel.menu)
			byte_next = {8{menu}};
	end

	// Register the byte and remember whether RAM owns the next cycle
	always_ff @(posedge clk_24)
	begin
		if (reset)
		begin
			din_r <= 8'h00;
			wkram_r <= 1'b0;
		end
		else
		begin
			din_r <= byte_next;
			wkram_r <= sel.wkram;
		end
	end

	// RAM output is already registered inside work_ram
	assign cpu_din = wkram_r ? ram_q : din_r;

endmodule

// ==== rtl/aznable_sys.sv ====
module aznable_sys
	import aznable_pkg::*;
#(
	parameter int CYCLES_PER_MS = 24000,
	parameter int RAM_ADDR_WIDTH = 14
) (
	input logic clk_24,
	input logic reset,
	input logic ce_6,
	input logic pause,
	input logic menu,
	input host_inputs_t inputs,
	input logic [15:0] cpu_addr,
	input logic [7:0] cpu_dout,
	input logic cpu_wr_n,
	output logic [7:0] cpu_din,
	output video_sync_t sync,
	output logic pause_system
);

	bus_sel_t sel;
	logic timer_clear;
	logic pause_set;
	logic menu_clear;
	logic menu_trigger;
	logic [15:0] timer;
	logic [7:0] ram_q;

	raster_timer u_raster_timer (
		.clk_24(clk_24),
		.reset(reset),
		.ce_6(ce_6),
		.sync(sync)
	);

	ms_timer #(
		.CYCLES_PER_MS(CYCLES_PER_MS)
	) u_ms_timer (
		.clk_24(clk_24),
		.reset(reset),
		.timer_clear(timer_clear),
		.count(timer)
	);

	bus_decode u_bus_decode (
		.cpu_addr(cpu_addr),
		.cpu_wr_n(cpu_wr_n),
		.sel(sel),
		.timer_clear(timer_clear),
		.pause_set(pause_set),
		.menu_clear(menu_clear)
	);

	system_regs u_system_regs (
		.clk_24(clk_24),
		.reset(reset),
		.pause(pause),
		.menu(menu),
		.pause_set(pause_set),
		.menu_clear(menu_clear),
		.pause_system(pause_system),
		.menu_trigger(menu_trigger)
	);

	// 16 KB at C000
	work_ram #(
		.RAM_ADDR_WIDTH(RAM_ADDR_WIDTH)
	) u_work_ram (
		.clk_24(clk_24),
		.sel(sel),
		.cpu_addr(cpu_addr),
		.cpu_wr_n(cpu_wr_n),
		.cpu_dout(cpu_dout),
		.q(ram_q)
	);

	cpu_read_mux u_cpu_read_mux (
		.clk_24(clk_24),
		.reset(reset),
		.cpu_addr(cpu_addr),
		.sel(sel),
		.inputs(inputs),
		.sync(sync),
		.menu(menu_trigger),
		.timer(timer),
		.ram_q(ram_q),
		.cpu_din(cpu_din)
	);

endmodule

// ==== dv/tb_clock.sv ====
module tb_clock (
	output logic clk_24,
	output logic reset
);
	timeunit 1ns;
	timeprecision 100ps;

	// 10 ns period
	initial
	begin
		clk_24 = 1'b0;
		forever
			#5 clk_24 = ~clk_24;
	end

	// Reset covers the first three rising edges
	initial
	begin
		reset = 1'b1;
		repeat (3)
			@(posedge clk_24);
		#1 reset = 1'b0;
	end

endmodule

// ==== dv/tb_aznable_sys.sv ====
module tb_aznable_sys
	import aznable_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int CYCLES_PER_MS = 50;
	localparam int FRAME_CYCLES = 384 * 262 * 4;
	localparam int RAM_OPS = 200;
	localparam int WIN_READS = 400;
	localparam int TIMER_ROUNDS = 6;
	// All phases at 10 ns per cycle and doubled for margin
	localparam int WATCHDOG_NS = 20 * (FRAME_CYCLES + 4 * RAM_OPS + 2 * WIN_READS
		+ TIMER_ROUNDS * 10 * CYCLES_PER_MS + 200);
	localparam logic [15:0] WIN_STARTS [8] = '{16'h8000, 16'h8002, 16'h802A, 16'h803A,
		16'h81BA, 16'h824A, 16'h82B6, 16'h82B7};

	logic clk_24;
	logic reset;
	logic ce_6;
	logic pause;
	logic menu;
	host_inputs_t host_in;
	logic [15:0] cpu_addr;
	logic [7:0] cpu_dout;
	logic cpu_wr_n;
	logic [7:0] cpu_din;
	video_sync_t sync_out;
	logic pause_system;

	logic [31:0] lfsr;
	logic [1:0] ce_phase;
	int m_h;
	int m_v;
	int m_pre;
	video_sync_t m_sync;
	video_sync_t prev_sync;
	logic m_menu;
	logic prev_menu;
	logic m_pause;
	logic [15:0] m_timer;
	logic [15:0] prev_timer;
	logic [7:0] ram_model [16384];
	logic [15:0] ram_addrs [$];

	tb_clock u_clock (
		.clk_24(clk_24),
		.reset(reset)
	);

	aznable_sys #(
		.CYCLES_PER_MS(CYCLES_PER_MS),
		.RAM_ADDR_WIDTH(14)
	) u_dut (
		.clk_24(clk_24),
		.reset(reset),
		.ce_6(ce_6),
		.pause(pause),
		.menu(menu),
		.inputs(host_in),
		.cpu_addr(cpu_addr),
		.cpu_dout(cpu_dout),
		.cpu_wr_n(cpu_wr_n),
		.cpu_din(cpu_din),
		.sync(sync_out),
		.pause_system(pause_system)
	);

	// Galois LFSR with taps 32, 22, 2 and 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = 32'd0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_next(lfsr);
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	task automatic check_equal(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("CHECK FAILED at %0d ns: %s got %0h, expected %0h", $time, name, got, exp);
			$display("Checks failed");
			$fatal(1, "Stopped at the first mismatch");
		end
	endtask

	task automatic step();
		@(posedge clk_24);
		#1;
	endtask

	task automatic bus_write(input logic [15:0] a, input logic [7:0] data);
		cpu_addr = a;
		cpu_dout = data;
		cpu_wr_n = 1'b0;
		if (a >= 16'hC000)
			ram_model[a[13:0]] = data;
		step();
		// Write-first RAM shows the new byte at once
		if (a >= 16'hC000)
			check_equal("cpu_din on RAM write", 32'(cpu_din), 32'(data));
		cpu_wr_n = 1'b1;
		cpu_addr = 16'h0000;
	endtask

	// Byte the CPU should see for an address under the memory map rules
	function automatic logic [7:0] expected_byte(input logic [15:0] a);
		if (a == 16'h8000)
			return {prev_sync.hs, prev_sync.vs, prev_sync.hb, prev_sync.vb, 2'b10,
				prev_menu, 1'b0};
		if (a >= 16'h8002 && a < 16'h8007)
			return 8'(host_in.timestamp >> (8 * (a - 16'h8002)));
		if (a >= 16'h802A && a < 16'h802C)
			return 8'(prev_timer >> (8 * (a - 16'h802A)));
		if (a >= 16'h803A && a < 16'h8052)
			return 8'(host_in.joystick >> (8 * (a - 16'h803A)));
		if (a >= 16'h81BA && a < 16'h81C0)
			return 8'(host_in.paddle >> (8 * (a - 16'h81BA)));
		if (a >= 16'h824A && a < 16'h824C)
			return 8'(host_in.ps2_key >> (8 * (a - 16'h824A)));
		if (a == 16'h82B7)
			return {8{prev_menu}};
		if (a >= 16'hC000)
			return ram_model[a[13:0]];
		return 8'h00;
	endfunction

	task automatic read_expect(input logic [15:0] a);
		cpu_addr = a;
		cpu_wr_n = 1'b1;
		step();
		check_equal($sformatf("cpu_din[%h]", a), 32'(cpu_din), 32'(expected_byte(a)));
	endtask

	task automatic ram_test();
		logic [15:0] a;
		repeat (RAM_OPS)
		begin
			a = 16'hC000 | 16'(rand_bits(14));
			ram_addrs.push_back(a);
			bus_write(a, 8'(rand_bits(8)));
		end
		repeat (RAM_OPS)
			read_expect(ram_addrs[rand_bits(8) % ram_addrs.size()]);
	endtask

	task automatic window_test();
		logic [15:0] a;
		for (int i = 0; i < WIN_READS; i++)
		begin
			if (i % 50 == 0)
				for (int b = 0; b < $bits(host_in); b++)
					host_in[b] = 1'(rand_bits(1));
			case (2'(rand_bits(2)))
				2'd0: a = 16'h8000 + 16'(rand_bits(10));
				2'd1: a = 16'h8000 | 16'(rand_bits(14));
				// Below 8000 nothing is mapped
				2'd2: a = 16'(rand_bits(15));
				default: a = WIN_STARTS[3'(rand_bits(3))] + 16'(rand_bits(5));
			endcase
			read_expect(a);
		end
	endtask

	task automatic timer_test();
		int k;
		int wait_cycles;
		repeat (TIMER_ROUNDS)
		begin
			k = int'(rand_bits(3));
			wait_cycles = k * CYCLES_PER_MS + int'(rand_bits(6) % 49);
			bus_write(16'h802A + 16'(rand_bits(4)), 8'(rand_bits(8)));
			repeat (wait_cycles)
				step();
			read_expect(16'h802A);
			check_equal("timer low byte", 32'(cpu_din), 32'(k));
			read_expect(16'h802B);
			check_equal("timer high byte", 32'(cpu_din), 32'(k >> 8));
		end
	endtask

	task automatic trigger_test();
		bus_write(16'h82B6, 8'(rand_bits(8)));
		step();
		check_equal("pause_system after pause write", 32'(pause_system), 32'd1);
		pause = 1'b1;
		step();
		pause = 1'b0;
		step();
		check_equal("pause_system after host pause", 32'(pause_system), 32'd0);
		menu = 1'b1;
		step();
		menu = 1'b0;
		read_expect(16'h82B7);
		check_equal("menu read after menu", 32'(cpu_din), 32'hFF);
		read_expect(16'h8000);
		bus_write(16'h82B7, 8'(rand_bits(8)));
		read_expect(16'h82B7);
		check_equal("menu read after clear", 32'(cpu_din), 32'h00);
		// Menu wins over a clear in the same cycle
		menu = 1'b1;
		bus_write(16'h82B7, 8'(rand_bits(8)));
		menu = 1'b0;
		read_expect(16'h82B7);
		check_equal("menu read, both same cycle", 32'(cpu_din), 32'hFF);
		// Host pause wins over a pause write in the same cycle
		pause = 1'b1;
		bus_write(16'h82B6, 8'(rand_bits(8)));
		pause = 1'b0;
		step();
		check_equal("pause_system, both same cycle", 32'(pause_system), 32'd0);
	endtask

	// Reference model updated on every rising edge
	always @(posedge clk_24)
	begin
		prev_sync = m_sync;
		prev_menu = m_menu;
		prev_timer = m_timer;
		if (reset)
		begin
			m_h = 0;
			m_v = 0;
			m_sync = '0;
			m_menu = 1'b0;
			m_pause = 1'b0;
			m_timer = 16'd0;
			m_pre = 0;
		end
		else
		begin
			if (ce_6)
			begin
				m_h = (m_h + 1) % 384;
				if (m_h == 0)
					m_v = (m_v + 1) % 262;
			end
			m_sync.hb = m_h >= 320;
			m_sync.vb = m_v >= 240;
			m_sync.hs = m_h >= 336 && m_h < 352;
			m_sync.vs = m_v >= 244 && m_v < 247;
			if (pause)
				m_pause = 1'b0;
			else if (!cpu_wr_n && cpu_addr == 16'h82B6)
				m_pause = 1'b1;
			if (menu)
				m_menu = 1'b1;
			else if (!cpu_wr_n && cpu_addr == 16'h82B7)
				m_menu = 1'b0;
			if (!cpu_wr_n && cpu_addr >= 16'h802A && cpu_addr < 16'h803A)
			begin
				m_timer = 16'd0;
				m_pre = 0;
			end
			else if (m_pre == CYCLES_PER_MS - 1)
			begin
				m_pre = 0;
				m_timer = m_timer + 16'd1;
			end
			else
				m_pre = m_pre + 1;
		end
	end

	// Sync and pause are compared every cycle away from the edge
	always @(negedge clk_24)
	begin
		if (!reset)
		begin
			check_equal("sync", 32'(sync_out), 32'(m_sync));
			check_equal("pause_system", 32'(pause_system), 32'(pause || m_pause));
		end
	end

	// Pixel enable is high one clock in four
	initial
	begin
		ce_6 = 1'b0;
		ce_phase = 2'd0;
		forever
		begin
			@(posedge clk_24);
			#1;
			ce_phase = ce_phase + 2'd1;
			ce_6 = ce_phase == 2'd0;
		end
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
		$display("Checks failed");
		$fatal(1, "Watchdog expired");
	end

	initial
	begin
		lfsr = 32'h6454;
		pause = 1'b0;
		menu = 1'b0;
		host_in = '0;
		cpu_addr = 16'h0000;
		cpu_dout = 8'h00;
		cpu_wr_n = 1'b1;
		wait (reset === 1'b0);
		// One full frame of raster timing for the negedge monitor
		repeat (FRAME_CYCLES + 8)
			step();
		ram_test();
		window_test();
		timer_test();
		trigger_test();
		$display("All checks passed");
		$finish;
	end

endmodule

// ==== aznable_sys.f ====
rtl/aznable_pkg.sv
rtl/raster_timer.sv
rtl/ms_timer.sv
rtl/bus_decode.sv
rtl/system_regs.sv
rtl/work_ram.sv
rtl/cpu_read_mux.sv
rtl/aznable_sys.sv
dv/tb_clock.sv
dv/tb_aznable_sys.sv

// ==== Makefile ====
# Verilator simulation of the aznable system core

TOP := tb_aznable_sys

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timescale 1ns/1ps -Wno-fatal --top-module $(TOP) \
		-f aznable_sys.f -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
